/* Makefile */
# Verilator build of mem_top_tb, exit status carries pass or fail

VERILATOR ?= verilator
TOP       ?= mem_top_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv testbench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* include/mem_defines.svh */
// Address map and widths for the load/store memory side
// Every access is a full 32-bit word, low two address bits are ignored
// Control-register offsets are byte offsets from CR_BASE
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Data memory region
`define D_MEM_WORDS 256
`define D_MEM_BASE  32'h0000_0000
`define D_MEM_TOP   32'h0000_03FF

// Control-register region, 256 bytes of offset space
`define CR_BASE     32'h0000_C000
`define CR_OFF_W    8

// Control-register offsets
`define CR_SEG7_0   8'h00
`define CR_SEG7_1   8'h04
`define CR_SEG7_2   8'h08
`define CR_SEG7_3   8'h0C
`define CR_SEG7_4   8'h10
`define CR_SEG7_5   8'h14
`define CR_LED      8'h18
`define CR_BUTTON_0 8'h1C
`define CR_BUTTON_1 8'h20
`define CR_SWITCH   8'h24

// Board register widths
`define LED_W       10
`define SWITCH_W    10

`endif

/* list.f */
+incdir+include
verilog/mem_pkg.sv
verilog/pipe_reg.sv
verilog/input_sync.sv
verilog/cr_mem.sv
verilog/data_mem.sv
verilog/mem_router.sv
verilog/mem_top.sv
testbench/mem_top_chk.sv
testbench/mem_top_tb.sv

/* testbench/mem_top_chk.sv */
// Handshake and reset assertions, bound into mem_top
// Stability and strobe checks are off while rst_n is low
`timescale 1ns/1ps

module mem_top_chk (
    input logic                Clk,
    input logic                rst_n,
    input logic                req_valid,
    input logic                req_ready,
    input mem_pkg::t_mem_req   req,
    input logic                rsp_valid,
    input logic                rsp_ready,
    input mem_pkg::t_mem_rsp   rsp,
    input logic                d_wren,
    input logic                d_rden,
    input logic                cr_wren,
    input logic                cr_rden
);

    // No response while held in reset
    a_rsp_reset: assert property (@(posedge Clk) !rst_n |-> !rsp_valid)
        else $error("rsp_valid high during reset");

    // Stalled response keeps valid and payload
    a_rsp_stable: assert property (@(posedge Clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response dropped or changed while stalled");

    // Same rule on the request side
    a_req_stable: assert property (@(posedge Clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request dropped or changed while stalled");

    // One memory strobe at most
    a_one_strobe: assert property (@(posedge Clk) disable iff (!rst_n)
        $onehot0({d_wren, d_rden, cr_wren, cr_rden}))
        else $error("more than one memory strobe high");

endmodule

/* testbench/mem_top_tb.sv */
// Self-checking testbench for mem_top
// Word-aligned addresses only, the data memory is filled before any load
// Board inputs are held steady while their registers are read
`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_top_tb;
    import mem_pkg::*;

    localparam int D_IDX_W    = $clog2(`D_MEM_WORDS);
    localparam int N_RAND_OPS = 120;
    localparam int N_GAP_OPS  = 150;
    // About 1700 cycles of traffic in total, limit gives over 2x margin
    localparam int TIMEOUT_CYCLES = 4000;
    // First seven are core writable, last three board written
    localparam logic [`CR_OFF_W-1:0] CR_OFFS [10] = '{
        `CR_SEG7_0, `CR_SEG7_1, `CR_SEG7_2, `CR_SEG7_3, `CR_SEG7_4,
        `CR_SEG7_5, `CR_LED, `CR_BUTTON_0, `CR_BUTTON_1, `CR_SWITCH
    };

    logic                 Clk;
    logic                 rst_n;
    logic                 req_valid;
    logic                 req_ready;
    t_mem_req             req;
    logic                 rsp_valid;
    logic                 rsp_ready;
    t_mem_rsp             rsp;
    logic                 button_0;
    logic                 button_1;
    logic [`SWITCH_W-1:0] switch;
    t_fpga_out            fpga_out;

    // Reference state, queue holds {rdata, addr} per accepted load
    logic [31:0] d_model [`D_MEM_WORDS];
    t_cr_rw      cr_model;
    t_cr_ro      ro_model;
    logic [63:0] exp_q [$];
    logic [31:0] lfsr_state = 32'h0d5b_a2c9;
    logic        gaps_on = 1'b0;
    int          cycle_count = 0;
    string       test_name = "reset";

    mem_top uut (
        .Clk(Clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .button_0(button_0), .button_1(button_1), .switch(switch),
        .fpga_out(fpga_out)
    );

    bind mem_top mem_top_chk chk (
        .Clk(Clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .d_wren(d_wren), .d_rden(d_rden), .cr_wren(cr_wren), .cr_rden(cr_rden)
    );

    // --------------------
    // Helpers
    // --------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] cr_byte_addr(input logic [`CR_OFF_W-1:0] off);
        return `CR_BASE + 32'(off);
    endfunction

    // Load result as the address map defines it
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] d_off;
        logic [31:0] cr_off;
        d_off  = addr - `D_MEM_BASE;
        cr_off = addr - `CR_BASE;
        if (d_off <= `D_MEM_TOP - `D_MEM_BASE)
            return d_model[d_off[2 +: D_IDX_W]];
        if (cr_off < (32'd1 << `CR_OFF_W)) begin
            case (cr_off[`CR_OFF_W-1:0])
                `CR_SEG7_0:   return 32'(cr_model.seg7_0);
                `CR_SEG7_1:   return 32'(cr_model.seg7_1);
                `CR_SEG7_2:   return 32'(cr_model.seg7_2);
                `CR_SEG7_3:   return 32'(cr_model.seg7_3);
                `CR_SEG7_4:   return 32'(cr_model.seg7_4);
                `CR_SEG7_5:   return 32'(cr_model.seg7_5);
                `CR_LED:      return 32'(cr_model.led);
                `CR_BUTTON_0: return 32'(ro_model.button_0);
                `CR_BUTTON_1: return 32'(ro_model.button_1);
                `CR_SWITCH:   return 32'(ro_model.switch);
                default:      return 32'd0;
            endcase
        end
        return 32'd0;
    endfunction

    // Store effect on the model, masked to register width
    task automatic apply_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] d_off;
        logic [31:0] cr_off;
        d_off  = addr - `D_MEM_BASE;
        cr_off = addr - `CR_BASE;
        if (d_off <= `D_MEM_TOP - `D_MEM_BASE)
            d_model[d_off[2 +: D_IDX_W]] = data;
        else if (cr_off < (32'd1 << `CR_OFF_W)) begin
            case (cr_off[`CR_OFF_W-1:0])
                `CR_SEG7_0: cr_model.seg7_0 = data[7:0];
                `CR_SEG7_1: cr_model.seg7_1 = data[7:0];
                `CR_SEG7_2: cr_model.seg7_2 = data[7:0];
                `CR_SEG7_3: cr_model.seg7_3 = data[7:0];
                `CR_SEG7_4: cr_model.seg7_4 = data[7:0];
                `CR_SEG7_5: cr_model.seg7_5 = data[7:0];
                `CR_LED:    cr_model.led    = data[`LED_W-1:0];
                default: ;
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // Hold the request until accepted, called at posedge + 1 ns
    task automatic send_req(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic wr);
        logic taken;
        taken     = 1'b0;
        req_valid = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        req.wr    = wr;
        while (!taken) begin
            // Inputs are stable mid-cycle, transfer lands on the next edge
            @(negedge Clk);
            if (req_ready) begin
                taken = 1'b1;
                if (wr)
                    apply_write(addr, wdata);
                else
                    exp_q.push_back({expected_read(addr), addr});
            end
            @(posedge Clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic random_dmem_op();
        logic [31:0] word;
        logic [31:0] op;
        logic [31:0] data;
        word = take_bits(D_IDX_W);
        op   = take_bits(1);
        data = take_bits(32);
        send_req(`D_MEM_BASE + (word << 2), data, op[0]);
    endtask

    task automatic store_then_load(input logic [31:0] addr);
        send_req(addr, take_bits(32), 1'b1);
        send_req(addr, 32'd0, 1'b0);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge Clk);
            #1;
        end
    endtask

    // --------------------
    // Clock, rsp_ready, timeout
    // --------------------

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // Gap bit drawn mid-cycle, applied after the edge, ready 3 of 4
    initial begin
        logic next_ready;
        rsp_ready = 1'b1;
        forever begin
            @(negedge Clk);
            next_ready = gaps_on ? (take_bits(2) != 32'd0) : 1'b1;
            @(posedge Clk);
            #1;
            rsp_ready = next_ready;
        end
    end

    always @(posedge Clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, DUT stalled or responses missing",
                     cycle_count);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // Response comparison
    // --------------------

    always @(negedge Clk) begin
        logic [63:0] expected;
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Response for address %h arrived with no load outstanding",
                         rsp.addr);
                $display("TEST FAILED");
                $fatal(1, "extra response");
            end else begin
                expected = exp_q.pop_front();
                check_value({test_name, " addr"}, 64'(expected[31:0]), 64'(rsp.addr));
                check_value({test_name, " rdata"}, 64'(expected[63:32]), 64'(rsp.rdata));
            end
        end
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        logic [31:0] bits;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        button_0  = 1'b0;
        button_1  = 1'b0;
        switch    = '0;
        cr_model  = '0;
        ro_model  = '0;
        repeat (5) @(posedge Clk);
        #1;
        rst_n = 1'b1;
        @(posedge Clk);
        #1;

        // Fill every word, then mixed traffic
        test_name = "dmem_random";
        for (int i = 0; i < `D_MEM_WORDS; i++)
            send_req(`D_MEM_BASE + (32'(i) << 2), take_bits(32), 1'b1);
        repeat (N_RAND_OPS) random_dmem_op();
        drain();

        // Segment and LED masking, board outputs
        test_name = "cr_rw";
        repeat (2) begin
            for (int i = 0; i < 7; i++)
                send_req(cr_byte_addr(CR_OFFS[i]), take_bits(32), 1'b1);
            for (int i = 0; i < 7; i++)
                send_req(cr_byte_addr(CR_OFFS[i]), 32'd0, 1'b0);
            drain();
            check_value({test_name, " fpga_out"}, 64'(cr_model), 64'(fpga_out));
        end

        // Buttons and switch, stores to them ignored
        test_name = "cr_ro";
        repeat (3) begin
            bits = take_bits(2 + `SWITCH_W);
            button_0 = bits[0];
            button_1 = bits[1];
            switch   = bits[2 +: `SWITCH_W];
            ro_model.button_0 = bits[0];
            ro_model.button_1 = bits[1];
            ro_model.switch   = bits[2 +: `SWITCH_W];
            repeat (5) @(posedge Clk);
            #1;
            for (int i = 7; i < 10; i++)
                send_req(cr_byte_addr(CR_OFFS[i]), take_bits(32), 1'b1);
            for (int i = 7; i < 10; i++)
                send_req(cr_byte_addr(CR_OFFS[i]), 32'd0, 1'b0);
            drain();
            check_value({test_name, " fpga_out"}, 64'(cr_model), 64'(fpga_out));
        end

        // Outside both regions, then a full sweep of every modeled location
        test_name = "unmapped";
        for (int i = 0; i < 8; i++)
            store_then_load((take_bits(30) << 2) | 32'h0001_0000);
        store_then_load(`D_MEM_TOP + 32'd1);
        store_then_load(`CR_BASE - 32'd4);
        store_then_load(cr_byte_addr(`CR_SWITCH + 8'h04));
        for (int i = 0; i < `D_MEM_WORDS; i++)
            send_req(`D_MEM_BASE + (32'(i) << 2), 32'd0, 1'b0);
        for (int i = 0; i < 10; i++)
            send_req(cr_byte_addr(CR_OFFS[i]), 32'd0, 1'b0);
        drain();
        check_value({test_name, " fpga_out"}, 64'(cr_model), 64'(fpga_out));

        // Back-pressure on the response port
        test_name = "rsp_gaps";
        gaps_on = 1'b1;
        repeat (N_GAP_OPS) random_dmem_op();
        drain();
        gaps_on = 1'b0;
        // Quiet time so a duplicate response would still show up
        repeat (10) @(posedge Clk);
        #1;
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verilog/cr_mem.sv */
// Control-register memory, flop based
// Core writes SEG7 and LED, reads all, BUTTON and SWITCH are board written
// address is the byte offset from CR_BASE, unknown offsets read zero
`timescale 1ns/1ps

`include "mem_defines.svh"

module cr_mem (
    input  logic                 Clk,
    input  logic                 rst_n,
    input  logic [31:0]          data,
    input  logic [`CR_OFF_W-1:0] address,
    input  logic                 wren,
    input  logic                 rden,
    output logic [31:0]          q,
    input  mem_pkg::t_cr_ro      sync_ro,
    output mem_pkg::t_fpga_out   fpga_out
);
    import mem_pkg::*;

    t_cr_rw      cr_rw;
    t_cr_rw      cr_rw_next;
    t_cr_ro      cr_ro;
    logic [31:0] pre_q;

    // --------------------
    // Store path
    // --------------------

    // Only the read/write set takes core stores
    always_comb begin
        cr_rw_next = cr_rw;
        if (wren) begin
            case (address)
                `CR_SEG7_0: cr_rw_next.seg7_0 = data[7:0];
                `CR_SEG7_1: cr_rw_next.seg7_1 = data[7:0];
                `CR_SEG7_2: cr_rw_next.seg7_2 = data[7:0];
                `CR_SEG7_3: cr_rw_next.seg7_3 = data[7:0];
                `CR_SEG7_4: cr_rw_next.seg7_4 = data[7:0];
                `CR_SEG7_5: cr_rw_next.seg7_5 = data[7:0];
                `CR_LED:    cr_rw_next.led    = data[`LED_W-1:0];
                // RO offsets and holes ignore the store
                default: ;
            endcase
        end
    end

    // Register sets, RO set sampled every cycle from the synchronizer
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            cr_rw <= '0;
            cr_ro <= '0;
        end else begin
            cr_rw <= cr_rw_next;
            cr_ro <= sync_ro;
        end
    end

    // --------------------
    // Load path
    // --------------------

    // Zero-extend whichever register is selected
    always_comb begin
        pre_q = 32'b0;
        if (rden) begin
            case (address)
                `CR_SEG7_0:   pre_q = {24'b0, cr_rw_next.seg7_0};
                `CR_SEG7_1:   pre_q = {24'b0, cr_rw_next.seg7_1};
                `CR_SEG7_2:   pre_q = {24'b0, cr_rw_next.seg7_2};
                `CR_SEG7_3:   pre_q = {24'b0, cr_rw_next.seg7_3};
                `CR_SEG7_4:   pre_q = {24'b0, cr_rw_next.seg7_4};
                `CR_SEG7_5:   pre_q = {24'b0, cr_rw_next.seg7_5};
                `CR_LED:      pre_q = {{(32-`LED_W){1'b0}}, cr_rw_next.led};
                // Board inputs as held in the RO register
                `CR_BUTTON_0: pre_q = {31'b0, cr_ro.button_0};
                `CR_BUTTON_1: pre_q = {31'b0, cr_ro.button_1};
                `CR_SWITCH:   pre_q = {{(32-`SWITCH_W){1'b0}}, cr_ro.switch};
                default:      pre_q = 32'b0;
            endcase
        end
    end

    // Registered load data and board outputs
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            q        <= 32'b0;
            fpga_out <= '0;
        end else begin
            q               <= pre_q;
            fpga_out.seg7_0 <= cr_rw_next.seg7_0;
            fpga_out.seg7_1 <= cr_rw_next.seg7_1;
            fpga_out.seg7_2 <= cr_rw_next.seg7_2;
            fpga_out.seg7_3 <= cr_rw_next.seg7_3;
            fpga_out.seg7_4 <= cr_rw_next.seg7_4;
            fpga_out.seg7_5 <= cr_rw_next.seg7_5;
            fpga_out.led    <= cr_rw_next.led;
        end
    end

endmodule

/* verilog/data_mem.sv */
// Word-addressed data memory built from flops
// No reset, contents and q are unknown until written or read
// q holds its last value while rden is low
`timescale 1ns/1ps

`include "mem_defines.svh"

module data_mem (
    input  logic                           Clk,
    input  logic [31:0]                    data,
    input  logic [$clog2(`D_MEM_WORDS)-1:0] address,
    input  logic                           wren,
    input  logic                           rden,
    output logic [31:0]                    q
);

    logic [31:0] mem [`D_MEM_WORDS];

    // --------------------
    // Store
    // --------------------

    // Synchronous full-word write
    always_ff @(posedge Clk) begin
        if (wren)
            mem[address] <= data;
    end

    // --------------------
    // Load
    // --------------------

    // Registered read, valid the cycle after rden
    always_ff @(posedge Clk) begin
        if (rden)
            q <= mem[address];
    end

endmodule

/* verilog/input_sync.sv */
// Two-flop synchronizer for the asynchronous board inputs
// Bits are synchronized one by one, a multi-bit switch change may be seen split
`timescale 1ns/1ps

`include "mem_defines.svh"

module input_sync (
    input  logic                 Clk,
    input  logic                 rst_n,
    input  logic                 button_0,
    input  logic                 button_1,
    input  logic [`SWITCH_W-1:0] switch,
    output mem_pkg::t_cr_ro      sync_ro
);
    import mem_pkg::*;

    t_cr_ro meta;

    // First stage may go metastable, second stage settles it
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            meta    <= '0;
            sync_ro <= '0;
        end else begin
            meta.button_0 <= button_0;
            meta.button_1 <= button_1;
            meta.switch   <= switch;
            sync_ro       <= meta;
        end
    end

endmodule

/* verilog/mem_pkg.sv */
// Shared struct types for the memory side
// Field widths come from mem_defines.svh

`include "mem_defines.svh"

package mem_pkg;

    // --------------------
    // Core request and response
    // --------------------

    // One word request, wr high for a store
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wr;
    } t_mem_req;

    // Load result, address kept for order checks
    typedef struct packed {
        logic [31:0] rdata;
        logic [31:0] addr;
    } t_mem_rsp;

    // --------------------
    // Control registers
    // --------------------

    // Core read/write set, raw segment bytes
    typedef struct packed {
        logic [7:0]        seg7_0;
        logic [7:0]        seg7_1;
        logic [7:0]        seg7_2;
        logic [7:0]        seg7_3;
        logic [7:0]        seg7_4;
        logic [7:0]        seg7_5;
        logic [`LED_W-1:0] led;
    } t_cr_rw;

    // Board-written set, read only from the core
    typedef struct packed {
        logic                 button_0;
        logic                 button_1;
        logic [`SWITCH_W-1:0] switch;
    } t_cr_ro;

    // Board outputs, mirror of the read/write set
    typedef struct packed {
        logic [7:0]        seg7_0;
        logic [7:0]        seg7_1;
        logic [7:0]        seg7_2;
        logic [7:0]        seg7_3;
        logic [7:0]        seg7_4;
        logic [7:0]        seg7_5;
        logic [`LED_W-1:0] led;
    } t_fpga_out;

endpackage

/* verilog/mem_router.sv */
// Routes core requests to the data memory or the control registers
// One read in flight at most, requests wait while it is pending
// Unmapped reads answer zero, unmapped writes are dropped
`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_router (
    input  logic                            Clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  mem_pkg::t_mem_req               req,
    output logic                            rsp_valid,
    input  logic                            rsp_ready,
    output mem_pkg::t_mem_rsp               rsp,
    output logic                            d_wren,
    output logic                            d_rden,
    output logic [$clog2(`D_MEM_WORDS)-1:0] d_addr,
    output logic                            cr_wren,
    output logic                            cr_rden,
    output logic [`CR_OFF_W-1:0]            cr_addr,
    output logic [31:0]                     wdata,
    input  logic [31:0]                     d_q,
    input  logic [31:0]                     cr_q
);
    import mem_pkg::*;

    localparam int D_ADDR_W = $clog2(`D_MEM_WORDS);
    localparam logic [31:0] CR_BASE_ADDR = `CR_BASE;

    logic        accept;
    logic        in_d;
    logic        in_cr;
    logic        rd_pend;
    logic        rd_from_d;
    logic        rd_from_cr;
    logic [31:0] rd_addr;

    // --------------------
    // Decode
    // --------------------

    // Region hits from the address map
    assign in_d  = (req.addr - `D_MEM_BASE) <= (`D_MEM_TOP - `D_MEM_BASE);
    assign in_cr = req.addr[31:`CR_OFF_W] == CR_BASE_ADDR[31:`CR_OFF_W];

    // Both terms are flops, response slot is free when taken
    assign req_ready = !rd_pend && rsp_ready;
    assign accept    = req_valid && req_ready;

    // Strobes gated by region
    assign d_wren  = accept && req.wr && in_d;
    assign d_rden  = accept && !req.wr && in_d;
    assign cr_wren = accept && req.wr && in_cr;
    assign cr_rden = accept && !req.wr && in_cr;

    // Word index and byte offset
    assign d_addr  = req.addr[2 +: D_ADDR_W];
    assign cr_addr = req.addr[`CR_OFF_W-1:0];
    assign wdata   = req.wdata;

    // --------------------
    // Read tracking
    // --------------------

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend    <= 1'b0;
            rd_from_d  <= 1'b0;
            rd_from_cr <= 1'b0;
        end else if (accept && !req.wr) begin
            rd_pend    <= 1'b1;
            rd_from_d  <= in_d;
            rd_from_cr <= in_cr;
        end else if (rsp_valid && rsp_ready) begin
            rd_pend <= 1'b0;
        end
    end

    // Address of the pending load, for the response
    always_ff @(posedge Clk) begin
        if (accept && !req.wr)
            rd_addr <= req.addr;
    end

    // Returning q, zero when neither region matched
    assign rsp_valid = rd_pend;
    assign rsp.addr  = rd_addr;
    assign rsp.rdata = rd_from_d  ? d_q  :
                       rd_from_cr ? cr_q : 32'b0;

endmodule

/* verilog/mem_top.sv */
// Load/store memory side of the core's FPGA build
// Word accesses only, writes produce no response
// Board inputs are asynchronous and synchronized here
`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_top (
    input  logic                 Clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  mem_pkg::t_mem_req    req,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output mem_pkg::t_mem_rsp    rsp,
    input  logic                 button_0,
    input  logic                 button_1,
    input  logic [`SWITCH_W-1:0] switch,
    output mem_pkg::t_fpga_out   fpga_out
);
    import mem_pkg::*;

    // Buffered request into the router
    logic     rq_valid;
    logic     rq_ready;
    t_mem_req rq;

    // Router output into the response buffer
    logic     rs_valid;
    logic     rs_ready;
    t_mem_rsp rs;

    // --------------------
    // Memory strobes
    // --------------------
    logic                            d_wren;
    logic                            d_rden;
    logic [$clog2(`D_MEM_WORDS)-1:0] d_addr;
    logic                            cr_wren;
    logic                            cr_rden;
    logic [`CR_OFF_W-1:0]            cr_addr;
    logic [31:0]                     wdata;
    logic [31:0]                     d_q;
    logic [31:0]                     cr_q;
    t_cr_ro                          sync_ro;

    pipe_reg #(.T_PAYLOAD(t_mem_req)) req_buf (
        .Clk(Clk), .rst_n(rst_n),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
        .out_valid(rq_valid), .out_ready(rq_ready), .out_data(rq)
    );

    mem_router router (
        .Clk(Clk), .rst_n(rst_n),
        .req_valid(rq_valid), .req_ready(rq_ready), .req(rq),
        .rsp_valid(rs_valid), .rsp_ready(rs_ready), .rsp(rs),
        .d_wren(d_wren), .d_rden(d_rden), .d_addr(d_addr),
        .cr_wren(cr_wren), .cr_rden(cr_rden), .cr_addr(cr_addr),
        .wdata(wdata), .d_q(d_q), .cr_q(cr_q)
    );

    pipe_reg #(.T_PAYLOAD(t_mem_rsp)) rsp_buf (
        .Clk(Clk), .rst_n(rst_n),
        .in_valid(rs_valid), .in_ready(rs_ready), .in_data(rs),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp)
    );

    data_mem d_mem (
        .Clk(Clk), .data(wdata), .address(d_addr),
        .wren(d_wren), .rden(d_rden), .q(d_q)
    );

    cr_mem cr_regs (
        .Clk(Clk), .rst_n(rst_n), .data(wdata), .address(cr_addr),
        .wren(cr_wren), .rden(cr_rden), .q(cr_q),
        .sync_ro(sync_ro), .fpga_out(fpga_out)
    );

    // Board inputs into the Clk domain
    input_sync in_sync (
        .Clk(Clk), .rst_n(rst_n),
        .button_0(button_0), .button_1(button_1), .switch(switch),
        .sync_ro(sync_ro)
    );

endmodule

/* verilog/pipe_reg.sv */
// Two-entry skid buffer on a valid/ready link
// in_ready and out_valid come from flops only
// Entry storage has no reset, only the occupancy does
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T_PAYLOAD = logic [31:0]
) (
    input  logic     Clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  T_PAYLOAD in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output T_PAYLOAD out_data
);

    T_PAYLOAD   entry [2];
    logic [1:0] count;
    logic       wr_ptr;
    logic       rd_ptr;
    logic       push;
    logic       pop;

    // Ready while a slot is free, valid while one is held
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Occupancy and pointers
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            count  <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            // Simultaneous push and pop leave count alone
            if (push && !pop)
                count <= count + 2'd1;
            else if (pop && !push)
                count <= count - 2'd1;
        end
    end

    // Payload slots
    always_ff @(posedge Clk) begin
        if (push)
            entry[wr_ptr] <= in_data;
    end

endmodule
